// File: weight_buffer.f
verilog/wbuf_types_pkg.sv
verilog/wbuf_ctrl_pkg.sv
verilog/wmem_if.sv
verilog/weight_sram.sv
verilog/wmem_arbiter.sv
verilog/weight_loader.sv
verilog/weight_fetch.sv
verilog/weight_buffer.sv
bench/tb_clock.sv
bench/weight_buffer_checker.sv
bench/weight_buffer_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the weight buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module weight_buffer_tb -f weight_buffer.f -o sim_weight_buffer

./obj_dir/sim_weight_buffer +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	echo "Run passed"
else
	echo "Run failed"
	exit 1
fi

// File: bench/weight_buffer_tb.sv
`timescale 1ns/10ps

module weight_buffer_tb;

	// About twice the length of all tests
	localparam int MAX_CYCLES = 6000;
	localparam int DEPTH      = 1024;
	localparam int DUAL_GAP   = 200;

	// Uncontended latency is reads plus two
	localparam int ROW3_LAT = 5;
	localparam int VEC8_LAT = 10;
	localparam int DUAL_LAT = 18;

	logic                    clk;
	logic                    arst_n;
	logic                    wb_cyc;
	logic                    wb_stb;
	logic                    wb_we;
	wbuf_types_pkg::waddr_t  wb_adr;
	wbuf_types_pkg::weight_t wb_dat_w;
	wbuf_types_pkg::weight_t wb_dat_r;
	logic                    wb_ack;
	logic                    fetch_start;
	logic [1:0]              fetch_shape;
	wbuf_types_pkg::widx_t   fetch_index;
	logic                    fetch_busy;
	logic                    fetch_done;
	wbuf_types_pkg::wvec_t   fetch_data1;
	wbuf_types_pkg::wvec_t   fetch_data2;

	// Mirror of every host write
	wbuf_types_pkg::weight_t model [DEPTH];

	int cycle_cnt;

	tb_clock i_clock (
		.clk (clk)
	);

	weight_buffer i_dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.fetch_start (fetch_start),
		.fetch_shape (fetch_shape),
		.fetch_index (fetch_index),
		.fetch_busy  (fetch_busy),
		.fetch_done  (fetch_done),
		.fetch_data1 (fetch_data1),
		.fetch_data2 (fetch_data2)
	);

	// ##########################################################
	// Helpers
	// ##########################################################

	task automatic compare_values(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Inputs move 2 ns after the edge
	task automatic next_cycle;
		@(posedge clk);
		#2;
	endtask

	// One Wishbone classic cycle
	task automatic host_access(
		input  logic                    we,
		input  wbuf_types_pkg::waddr_t  adr,
		input  wbuf_types_pkg::weight_t wdat,
		output wbuf_types_pkg::weight_t rdat
	);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdat;
		next_cycle();
		// Wait states until ack
		while (!wb_ack)
		begin
			next_cycle();
		end
		rdat = wb_dat_r;
		// Strobe held through the ack cycle
		next_cycle();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic host_write(input wbuf_types_pkg::waddr_t adr,
		input wbuf_types_pkg::weight_t data);
		wbuf_types_pkg::weight_t unused;
		host_access(1'b1, adr, data, unused);
		model[adr] = data;
	endtask

	task automatic host_read_check(input wbuf_types_pkg::waddr_t adr);
		wbuf_types_pkg::weight_t got;
		host_access(1'b0, adr, '0, got);
		compare_values("wb_dat_r", got, model[adr]);
	endtask

	// Group contents from the lane rules and the model
	function automatic void expected_group(
		input  logic [1:0]            shape,
		input  wbuf_types_pkg::widx_t idx,
		output wbuf_types_pkg::wvec_t v1,
		output wbuf_types_pkg::wvec_t v2
	);
		int base;
		int k;
		v1 = '0;
		v2 = '0;
		if (shape == wbuf_ctrl_pkg::SHAPE_ROW3)
		begin
			// Kernel row at 3 x index
			base = (3 * int'(idx)) % DEPTH;
			for (k = 0; k < 3; k++)
			begin
				v1[16*k +: 16] = model[(base + k) % DEPTH];
			end
		end
		else
		begin
			// Reserved code behaves like VEC8
			base = (8 * int'(idx)) % DEPTH;
			for (k = 0; k < 8; k++)
			begin
				v1[16*k +: 16] = model[(base + k) % DEPTH];
				if (shape == wbuf_ctrl_pkg::SHAPE_DUAL)
				begin
					v2[16*k +: 16] = model[(base + DUAL_GAP + k) % DEPTH];
				end
			end
		end
	endfunction

	// Latency of zero skips the timing check
	task automatic run_fetch(input logic [1:0] shape, input wbuf_types_pkg::widx_t idx,
		input int exp_lat);
		wbuf_types_pkg::wvec_t exp1;
		wbuf_types_pkg::wvec_t exp2;
		int lat;
		while (fetch_busy)
		begin
			next_cycle();
		end
		expected_group(shape, idx, exp1, exp2);
		fetch_shape = shape;
		fetch_index = idx;
		fetch_start = 1'b1;
		next_cycle();
		fetch_start = 1'b0;
		lat = 1;
		while (!fetch_done)
		begin
			next_cycle();
			lat++;
		end
		compare_values("fetch_data1", fetch_data1, exp1);
		compare_values("fetch_data2", fetch_data2, exp2);
		if (exp_lat > 0)
		begin
			compare_values("fetch latency", lat, exp_lat);
		end
	endtask

	task automatic check_outputs_zero;
		compare_values("wb_ack", wb_ack, 0);
		compare_values("wb_dat_r", wb_dat_r, 0);
		compare_values("fetch_busy", fetch_busy, 0);
		compare_values("fetch_done", fetch_done, 0);
		compare_values("fetch_data1", fetch_data1, 0);
		compare_values("fetch_data2", fetch_data2, 0);
	endtask

	// ##########################################################
	// Directed tests
	// ##########################################################

	task automatic load_and_read_back;
		int a;
		for (a = 0; a < DEPTH; a++)
		begin
			host_write(wbuf_types_pkg::waddr_t'(a), wbuf_types_pkg::weight_t'($urandom));
		end
		for (a = 0; a < 64; a++)
		begin
			host_read_check(wbuf_types_pkg::waddr_t'($urandom % DEPTH));
		end
	endtask

	task automatic fetch_rows;
		run_fetch(wbuf_ctrl_pkg::SHAPE_ROW3, 16'd0, ROW3_LAT);
		run_fetch(wbuf_ctrl_pkg::SHAPE_ROW3, 16'd1, ROW3_LAT);
		run_fetch(wbuf_ctrl_pkg::SHAPE_ROW3, 16'd100, ROW3_LAT);
		// Words 1023, 0 and 1
		run_fetch(wbuf_ctrl_pkg::SHAPE_ROW3, 16'd341, ROW3_LAT);
		run_fetch(wbuf_ctrl_pkg::SHAPE_ROW3, 16'hfff0, ROW3_LAT);
	endtask

	task automatic fetch_vectors;
		run_fetch(wbuf_ctrl_pkg::SHAPE_VEC8, 16'd0, VEC8_LAT);
		run_fetch(wbuf_ctrl_pkg::SHAPE_VEC8, 16'd5, VEC8_LAT);
		run_fetch(wbuf_ctrl_pkg::SHAPE_VEC8, 16'd127, VEC8_LAT);
		run_fetch(wbuf_ctrl_pkg::SHAPE_VEC8, 16'd300, VEC8_LAT);
		// Reserved code 3
		run_fetch(2'd3, 16'd9, VEC8_LAT);
	endtask

	task automatic fetch_dual;
		run_fetch(wbuf_ctrl_pkg::SHAPE_DUAL, 16'd0, DUAL_LAT);
		run_fetch(wbuf_ctrl_pkg::SHAPE_DUAL, 16'd10, DUAL_LAT);
		run_fetch(wbuf_ctrl_pkg::SHAPE_DUAL, 16'd100, DUAL_LAT);
		// Second vector starts at 1024 and wraps to 0
		run_fetch(wbuf_ctrl_pkg::SHAPE_DUAL, 16'd103, DUAL_LAT);
		run_fetch(wbuf_ctrl_pkg::SHAPE_DUAL, 16'd127, DUAL_LAT);
	endtask

	// Group at 160 and 360 with host writes from 600 up
	task automatic fetch_under_contention;
		int a;
		fork
			run_fetch(wbuf_ctrl_pkg::SHAPE_DUAL, 16'd20, 0);
			begin
				for (a = 600; a < 616; a++)
				begin
					host_write(wbuf_types_pkg::waddr_t'(a),
						wbuf_types_pkg::weight_t'($urandom));
				end
			end
		join
		for (a = 600; a < 616; a++)
		begin
			host_read_check(wbuf_types_pkg::waddr_t'(a));
		end
	endtask

	task automatic busy_and_reset;
		wbuf_types_pkg::wvec_t exp1;
		wbuf_types_pkg::wvec_t exp2;
		while (fetch_busy)
		begin
			next_cycle();
		end
		expected_group(wbuf_ctrl_pkg::SHAPE_VEC8, 16'd40, exp1, exp2);
		fetch_shape = wbuf_ctrl_pkg::SHAPE_VEC8;
		fetch_index = 16'd40;
		fetch_start = 1'b1;
		next_cycle();
		fetch_start = 1'b0;
		compare_values("fetch_busy", fetch_busy, 1);
		repeat (2)
		begin
			next_cycle();
		end
		// Second request while busy must be dropped
		fetch_shape = wbuf_ctrl_pkg::SHAPE_DUAL;
		fetch_index = 16'd41;
		fetch_start = 1'b1;
		next_cycle();
		fetch_start = 1'b0;
		while (!fetch_done)
		begin
			next_cycle();
		end
		compare_values("fetch_data1", fetch_data1, exp1);
		compare_values("fetch_data2", fetch_data2, exp2);
		// Start in the done cycle while busy is still high
		fetch_start = 1'b1;
		next_cycle();
		fetch_start = 1'b0;
		repeat (3)
		begin
			next_cycle();
		end
		compare_values("fetch_busy", fetch_busy, 0);
		compare_values("fetch_data1", fetch_data1, exp1);
		// Asynchronous clear of held results
		arst_n = 1'b0;
		#1;
		check_outputs_zero();
		repeat (3)
		begin
			next_cycle();
		end
		arst_n = 1'b1;
		check_outputs_zero();
	endtask

	// ##########################################################
	// Watchdog
	// ##########################################################

	always @(negedge clk)
	begin
		cycle_cnt++;
		if (i_dut.i_checker.assert_fails != 0)
		begin
			$display("A bound assertion failed, see the error above");
			$display("Simulation finished: FAIL");
			$fatal(1, "Assertion failure");
		end
		else if (cycle_cnt >= MAX_CYCLES)
		begin
			$display("Timeout: the run did not end within %0d clock cycles", MAX_CYCLES);
			$display("Simulation finished: FAIL");
			$fatal(1, "Timeout");
		end
	end

	initial
	begin
		arst_n      = 1'b0;
		wb_cyc      = 1'b0;
		wb_stb      = 1'b0;
		wb_we       = 1'b0;
		wb_adr      = '0;
		wb_dat_w    = '0;
		fetch_start = 1'b0;
		fetch_shape = '0;
		fetch_index = '0;
		cycle_cnt   = 0;
		void'($urandom(88));
		repeat (3)
		begin
			@(posedge clk);
		end
		#2;
		arst_n = 1'b1;
		check_outputs_zero();
		load_and_read_back();
		fetch_rows();
		fetch_vectors();
		fetch_dual();
		fetch_under_contention();
		busy_and_reset();
		if (i_dut.i_checker.assert_fails == 0)
		begin
			$display("Simulation finished: PASS");
		end
		else
		begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// File: bench/weight_buffer_checker.sv
`timescale 1ns/10ps

module weight_buffer_checker (
	input logic clk,
	input logic arst_n,
	input logic ld_gnt,
	input logic fe_gnt,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic fetch_done,
	input logic fetch_busy
);

	// Failures so far, polled by the testbench
	int assert_fails = 0;

	// ##########################################################
	// Arbitration
	// ##########################################################

	// One master on the RAM per cycle
	grant_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		!(ld_gnt && fe_gnt))
	else
	begin
		assert_fails++;
		$error("Loader and fetch unit granted in the same cycle");
	end

	// ##########################################################
	// Host and fetch handshakes
	// ##########################################################

	// Ack only inside an open strobe
	ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(wb_ack) |-> (wb_cyc && wb_stb))
	else
	begin
		assert_fails++;
		$error("wb_ack rose outside a Wishbone strobe");
	end

	// Done is a single pulse
	done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		fetch_done |=> !fetch_done)
	else
	begin
		assert_fails++;
		$error("fetch_done high for two cycles");
	end

	// Ready for a new start right after done
	idle_after_done: assert property (@(posedge clk) disable iff (!arst_n)
		fetch_done |=> !fetch_busy)
	else
	begin
		assert_fails++;
		$error("fetch_busy still high in the cycle after fetch_done");
	end

endmodule

// Grants live in the two memory interfaces of the top level
bind weight_buffer weight_buffer_checker i_checker (
	.clk        (clk),
	.arst_n     (arst_n),
	.ld_gnt     (ld_mem_if.gnt),
	.fe_gnt     (fe_mem_if.gnt),
	.wb_cyc     (wb_cyc),
	.wb_stb     (wb_stb),
	.wb_ack     (wb_ack),
	.fetch_done (fetch_done),
	.fetch_busy (fetch_busy)
);

// File: bench/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
	output logic clk
);

	// Half of the 20 ns period
	localparam time HALF_PERIOD = 10ns;

	initial
	begin
		clk = 1'b0;
	end

	// Free running, the bench stops the run
	always #HALF_PERIOD clk = ~clk;

endmodule

// File: verilog/weight_buffer.sv
`timescale 1ns/10ps

module weight_buffer (
	input  logic                    clk,
	input  logic                    arst_n,
	// Host port, Wishbone classic
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  wbuf_types_pkg::waddr_t  wb_adr,
	input  wbuf_types_pkg::weight_t wb_dat_w,
	output wbuf_types_pkg::weight_t wb_dat_r,
	output logic                    wb_ack,
	// Compute side fetch port
	input  logic                    fetch_start,
	input  logic [1:0]              fetch_shape,
	input  wbuf_types_pkg::widx_t   fetch_index,
	output logic                    fetch_busy,
	output logic                    fetch_done,
	output wbuf_types_pkg::wvec_t   fetch_data1,
	output wbuf_types_pkg::wvec_t   fetch_data2
);

	// Arbiter to RAM
	logic                    mem_en;
	logic                    mem_we;
	wbuf_types_pkg::waddr_t  mem_addr;
	wbuf_types_pkg::weight_t mem_wdata;
	wbuf_types_pkg::weight_t mem_rdata;

	// One path per master
	wmem_if ld_mem_if ();
	wmem_if fe_mem_if ();

	weight_loader i_loader (
		.clk      (clk),
		.arst_n   (arst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.mem      (ld_mem_if.master)
	);

	// Raw shape code cast to the enum, reserved code included
	weight_fetch i_fetch (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (fetch_start),
		.shape  (wbuf_ctrl_pkg::fetch_shape_e'(fetch_shape)),
		.index  (fetch_index),
		.busy   (fetch_busy),
		.done   (fetch_done),
		.data1  (fetch_data1),
		.data2  (fetch_data2),
		.mem    (fe_mem_if.master)
	);

	wmem_arbiter i_arbiter (
		.clk       (clk),
		.arst_n    (arst_n),
		.ld        (ld_mem_if.arbiter),
		.fe        (fe_mem_if.arbiter),
		.mem_en    (mem_en),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata)
	);

	weight_sram i_sram (
		.clk   (clk),
		.en    (mem_en),
		.we    (mem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rdata (mem_rdata)
	);

endmodule

// File: verilog/weight_fetch.sv
`timescale 1ns/10ps

module weight_fetch (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        start,
	input  wbuf_ctrl_pkg::fetch_shape_e shape,
	input  wbuf_types_pkg::widx_t       index,
	output logic                        busy,
	output logic                        done,
	output wbuf_types_pkg::wvec_t       data1,
	output wbuf_types_pkg::wvec_t       data2,
	wmem_if.master                      mem
);

	wbuf_ctrl_pkg::fetch_state_e state;

	// Decoded group, latched on start
	wbuf_types_pkg::waddr_t shape_base;
	wbuf_ctrl_pkg::rcnt_t   shape_last;
	wbuf_types_pkg::waddr_t base_r;
	wbuf_ctrl_pkg::rcnt_t   last_r;

	// Reads issued and reads returned
	wbuf_ctrl_pkg::rcnt_t issue_cnt;
	wbuf_ctrl_pkg::rcnt_t ret_cnt;

	wbuf_types_pkg::waddr_t second_off;
	logic                   accept;

	// Held off during done so the next start sees busy low first
	assign busy   = (state != wbuf_ctrl_pkg::FETCH_IDLE) || done;
	assign accept = start && !busy;

	// ##########################################################
	// Shape decode
	// ##########################################################

	always_comb
	begin
		shape_base = {index[6:0], 3'b000};
		shape_last = wbuf_ctrl_pkg::rcnt_t'(wbuf_ctrl_pkg::VEC8_READS - 1);
		case (shape)
			// Three words at index times three
			wbuf_ctrl_pkg::SHAPE_ROW3:
			begin
				shape_base = {index[8:0], 1'b0} + index[9:0];
				shape_last = wbuf_ctrl_pkg::rcnt_t'(wbuf_ctrl_pkg::ROW3_READS - 1);
			end
			wbuf_ctrl_pkg::SHAPE_DUAL:
			begin
				shape_last = wbuf_ctrl_pkg::rcnt_t'(wbuf_ctrl_pkg::DUAL_READS - 1);
			end
			// Reserved code falls back to VEC8
			wbuf_ctrl_pkg::SHAPE_VEC8, wbuf_ctrl_pkg::SHAPE_RSVD:
			begin
				shape_last = wbuf_ctrl_pkg::rcnt_t'(wbuf_ctrl_pkg::VEC8_READS - 1);
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			base_r <= shape_base;
			last_r <= shape_last;
		end
	end

	// ##########################################################
	// Issue side
	// ##########################################################

	// Reads 8 to 15 go to the second vector
	assign second_off = issue_cnt[3] ? wbuf_ctrl_pkg::DUAL_OFFSET : '0;

	assign mem.req   = (state == wbuf_ctrl_pkg::FETCH_ISSUE);
	assign mem.we    = 1'b0;
	assign mem.wdata = '0;
	assign mem.addr  = base_r + second_off + {7'd0, issue_cnt[2:0]};

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state     <= wbuf_ctrl_pkg::FETCH_IDLE;
			issue_cnt <= '0;
			ret_cnt   <= '0;
			done      <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (mem.rvalid)
			begin
				ret_cnt <= ret_cnt + 1'b1;
			end
			case (state)
				wbuf_ctrl_pkg::FETCH_IDLE:
				begin
					if (accept)
					begin
						state     <= wbuf_ctrl_pkg::FETCH_ISSUE;
						issue_cnt <= '0;
						ret_cnt   <= '0;
					end
				end
				// One read per granted cycle
				wbuf_ctrl_pkg::FETCH_ISSUE:
				begin
					if (mem.gnt)
					begin
						issue_cnt <= issue_cnt + 1'b1;
						if (issue_cnt == last_r)
						begin
							state <= wbuf_ctrl_pkg::FETCH_DRAIN;
						end
					end
				end
				// Wait for the last word
				default:
				begin
					if (mem.rvalid && ret_cnt == last_r)
					begin
						state <= wbuf_ctrl_pkg::FETCH_IDLE;
						done  <= 1'b1;
					end
				end
			endcase
		end
	end

	// ##########################################################
	// Return side
	// ##########################################################

	// Word n goes to lane n mod 8, vector by bit 3
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			data1 <= '0;
			data2 <= '0;
		end
		else if (accept)
		begin
			data1 <= '0;
			data2 <= '0;
		end
		else if (mem.rvalid)
		begin
			if (ret_cnt[3])
			begin
				data2[ret_cnt[2:0]*wbuf_types_pkg::WEIGHT_W +: wbuf_types_pkg::WEIGHT_W] <= mem.rdata;
			end
			else
			begin
				data1[ret_cnt[2:0]*wbuf_types_pkg::WEIGHT_W +: wbuf_types_pkg::WEIGHT_W] <= mem.rdata;
			end
		end
	end

endmodule

// File: verilog/weight_loader.sv
`timescale 1ns/10ps

module weight_loader (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  wbuf_types_pkg::waddr_t  wb_adr,
	input  wbuf_types_pkg::weight_t wb_dat_w,
	output wbuf_types_pkg::weight_t wb_dat_r,
	output logic                    wb_ack,
	wmem_if.master                  mem
);

	wbuf_ctrl_pkg::wb_state_e state;

	// Host cycle captured on entry to WAIT
	logic                    we_r;
	wbuf_types_pkg::waddr_t  adr_r;
	wbuf_types_pkg::weight_t dat_r;

	// ##########################################################
	// Host cycle FSM
	// ##########################################################

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= wbuf_ctrl_pkg::WB_IDLE;
		end
		else
		begin
			case (state)
				wbuf_ctrl_pkg::WB_IDLE:
				begin
					if (wb_cyc && wb_stb)
					begin
						state <= wbuf_ctrl_pkg::WB_WAIT;
					end
				end
				// Read data lands in the ack cycle
				wbuf_ctrl_pkg::WB_WAIT:
				begin
					if (mem.gnt)
					begin
						state <= wbuf_ctrl_pkg::WB_ACK;
					end
				end
				// Always back to idle, no new access here
				default:
				begin
					state <= wbuf_ctrl_pkg::WB_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == wbuf_ctrl_pkg::WB_IDLE && wb_cyc && wb_stb)
		begin
			we_r  <= wb_we;
			adr_r <= wb_adr;
			dat_r <= wb_dat_w;
		end
	end

	// Memory request held until granted
	assign mem.req   = (state == wbuf_ctrl_pkg::WB_WAIT);
	assign mem.we    = we_r;
	assign mem.addr  = adr_r;
	assign mem.wdata = dat_r;

	// Ack one cycle after grant, together with rvalid on reads
	assign wb_ack   = (state == wbuf_ctrl_pkg::WB_ACK);
	assign wb_dat_r = mem.rvalid ? mem.rdata : '0;

endmodule

// File: verilog/wmem_arbiter.sv
`timescale 1ns/10ps

module wmem_arbiter (
	input  logic                    clk,
	input  logic                    arst_n,
	wmem_if.arbiter                 ld,
	wmem_if.arbiter                 fe,
	output logic                    mem_en,
	output logic                    mem_we,
	output wbuf_types_pkg::waddr_t  mem_addr,
	output wbuf_types_pkg::weight_t mem_wdata,
	input  wbuf_types_pkg::weight_t mem_rdata
);

	// Round-robin history, high when the loader won last
	logic last_ld;
	logic gnt_ld;
	logic gnt_fe;

	// Owner of the read in flight
	logic rd_ld;
	logic rd_fe;

	// ##########################################################
	// Grant
	// ##########################################################

	// Fetch wins a tie unless it was served last
	assign gnt_fe = fe.req && (!ld.req || last_ld);
	assign gnt_ld = ld.req && !gnt_fe;

	assign ld.gnt = gnt_ld;
	assign fe.gnt = gnt_fe;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			last_ld <= 1'b1;
		end
		else if (gnt_ld || gnt_fe)
		begin
			last_ld <= gnt_ld;
		end
	end

	// ##########################################################
	// RAM port mux
	// ##########################################################

	assign mem_en    = gnt_ld || gnt_fe;
	assign mem_we    = gnt_fe ? fe.we    : ld.we;
	assign mem_addr  = gnt_fe ? fe.addr  : ld.addr;
	assign mem_wdata = gnt_fe ? fe.wdata : ld.wdata;

	// Remember who owns next cycle's read data
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rd_ld <= 1'b0;
			rd_fe <= 1'b0;
		end
		else
		begin
			rd_ld <= gnt_ld && !ld.we;
			rd_fe <= gnt_fe && !fe.we;
		end
	end

	assign ld.rvalid = rd_ld;
	assign fe.rvalid = rd_fe;
	// Data shared, qualified by rvalid
	assign ld.rdata  = mem_rdata;
	assign fe.rdata  = mem_rdata;

endmodule

// File: verilog/weight_sram.sv
`timescale 1ns/10ps

module weight_sram (
	input  logic                    clk,
	input  logic                    en,
	input  logic                    we,
	input  wbuf_types_pkg::waddr_t  addr,
	input  wbuf_types_pkg::weight_t wdata,
	output wbuf_types_pkg::weight_t rdata
);

	// Behavioural model of the weight macro
	wbuf_types_pkg::weight_t mem [wbuf_types_pkg::WMEM_DEPTH];

	// Single port, one access per cycle
	always_ff @(posedge clk)
	begin
		if (en)
		begin
			if (we)
			begin
				mem[addr] <= wdata;
			end
			else
			begin
				// Registered read, data next cycle
				rdata <= mem[addr];
			end
		end
	end

endmodule

// File: verilog/wmem_if.sv
`timescale 1ns/10ps

interface wmem_if;

	// Request side, driven by the master
	logic                   req;
	logic                   we;
	wbuf_types_pkg::waddr_t addr;
	wbuf_types_pkg::weight_t wdata;

	// Response side, driven by the arbiter
	logic                    gnt;
	logic                    rvalid;
	wbuf_types_pkg::weight_t rdata;

	// Access accepted when req and gnt both high
	modport master (
		output req,
		output we,
		output addr,
		output wdata,
		input  gnt,
		input  rvalid,
		input  rdata
	);

	// rvalid one cycle after an accepted read
	modport arbiter (
		input  req,
		input  we,
		input  addr,
		input  wdata,
		output gnt,
		output rvalid,
		output rdata
	);

endinterface

// File: verilog/wbuf_ctrl_pkg.sv
package wbuf_ctrl_pkg;

	// ##########################################################
	// Fetch shapes
	// ##########################################################

	// Code 3 reserved, decoded like VEC8
	typedef enum logic [1:0] {
		SHAPE_ROW3 = 2'd0,
		SHAPE_VEC8 = 2'd1,
		SHAPE_DUAL = 2'd2,
		SHAPE_RSVD = 2'd3
	} fetch_shape_e;

	// Reads per group for each shape
	localparam int ROW3_READS = 3;
	localparam int VEC8_READS = 8;
	localparam int DUAL_READS = 16;

	// Read counter, covers up to 16 reads
	typedef logic [3:0] rcnt_t;

	// Word distance to the second vector of a dual fetch
	localparam wbuf_types_pkg::waddr_t DUAL_OFFSET = 10'd200;

	// ##########################################################
	// State machines
	// ##########################################################

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_ISSUE,
		FETCH_DRAIN
	} fetch_state_e;

	typedef enum logic [1:0] {
		WB_IDLE,
		WB_WAIT,
		WB_ACK
	} wb_state_e;

endpackage

// File: verilog/wbuf_types_pkg.sv
package wbuf_types_pkg;

	// ##########################################################
	// Data widths
	// ##########################################################

	// One weight word
	localparam int WEIGHT_W = 16;

	// Lanes per output vector
	localparam int VEC_LANES = 8;
	localparam int VEC_W     = VEC_LANES * WEIGHT_W;

	// Fetch group index from compute side
	localparam int IDX_W = 16;

	// ##########################################################
	// Memory geometry
	// ##########################################################

	localparam int ADDR_W     = 10;
	localparam int WMEM_DEPTH = 1 << ADDR_W;

	typedef logic [WEIGHT_W-1:0] weight_t;

	// Word address, all arithmetic wraps at WMEM_DEPTH
	typedef logic [ADDR_W-1:0] waddr_t;

	// Lane k at bits 16k+15 down to 16k
	typedef logic [VEC_W-1:0] wvec_t;

	typedef logic [IDX_W-1:0] widx_t;

endpackage
